/* compile.f */
+incdir+include
verilog/vic_color_pkg.sv
verilog/luma_path.sv
verilog/chroma_path.sv
verilog/composite_mixer.sv
verilog/composite_encoder.sv
tb/tb_composite_encoder.sv

/* Bender.yml */
package:
  name: composite_encoder

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/vic_color_pkg.sv
      - verilog/luma_path.sv
      - verilog/chroma_path.sv
      - verilog/composite_mixer.sv
      - verilog/composite_encoder.sv

  - target: test
    include_dirs:
      - include
    files:
      - tb/tb_composite_encoder.sv

/* tb/tb_composite_encoder.sv */
`timescale 1ns/1ns

`include "composite_defs.svh"

module tb_composite_encoder;

        localparam int group_len     = 8; // two subcarrier turns per colour
        localparam int reset_cycles  = 4;
        localparam int unmod_cycles  = 5 * 2 * group_len;
        localparam int mod_cycles    = 11 * 2 * group_len;
        localparam int ctrl_cycles   = 5 * 2 * group_len;
        localparam int random_cycles = 1536; // 24 lines of 64 pixels
        localparam int line_len      = 64;
        localparam int total_cycles  = reset_cycles + unmod_cycles + mod_cycles
                                       + ctrl_cycles + random_cycles + 4;
        localparam int watchdog_ns   = (total_cycles + 20) * 4;
        localparam real half_pi      = 1.5707963267948966;

        logic                          clk;
        logic                          rst;
        vic_color_pkg::vic_color_t     index;
        logic                          oddline;
        logic                          sync;
        logic                          blank;
        logic                          burst;
        logic [`COMPOSITE_W-1:0]       composite;

        logic [`PHASE_W-1:0]           model_acc;     // mirrors the subcarrier
        logic [`COMPOSITE_W-1:0]       exp_stage1;    // expected after first stage
        logic [`COMPOSITE_W-1:0]       exp_composite; // expected at the output
        integer                        seed = 32'hee27_e81b;

        vic_color_pkg::vic_color_t grey_colors [5] = '{
                vic_color_pkg::black, vic_color_pkg::white, vic_color_pkg::dark_grey,
                vic_color_pkg::grey, vic_color_pkg::light_grey
        };
        vic_color_pkg::vic_color_t hue_colors [11] = '{
                vic_color_pkg::red, vic_color_pkg::cyan, vic_color_pkg::purple,
                vic_color_pkg::green, vic_color_pkg::blue, vic_color_pkg::yellow,
                vic_color_pkg::orange, vic_color_pkg::brown, vic_color_pkg::pink,
                vic_color_pkg::light_green, vic_color_pkg::light_blue
        };

        composite_encoder i_dut (
                .clk       (clk),
                .rst       (rst),
                .index     (index),
                .oddline   (oddline),
                .sync      (sync),
                .blank     (blank),
                .burst     (burst),
                .composite (composite)
        );

        initial begin
                clk = 1'b0;
                forever #2 clk = ~clk; // 4 ns period
        end

        task automatic abort_run(input string what);
                $display("%s", what);
                $display("Simulation failed");
                $fatal(1);
        endtask

        // reference palette luma with sync over blank over table
        function automatic int luma_of(input vic_color_pkg::vic_color_t c, input logic s,
                                       input logic b);
                if (s) return `SYNC_LUMA;
                if (b) return `BLANK_LUMA;
                case (c)
                        vic_color_pkg::black:       return 19;
                        vic_color_pkg::white:       return 59; // brightest code
                        vic_color_pkg::red:         return 31;
                        vic_color_pkg::cyan:        return 44;
                        vic_color_pkg::purple:      return 34;
                        vic_color_pkg::green:       return 39;
                        vic_color_pkg::blue:        return 28;
                        vic_color_pkg::yellow:      return 50;
                        vic_color_pkg::orange:      return 34;
                        vic_color_pkg::brown:       return 28;
                        vic_color_pkg::pink:        return 39;
                        vic_color_pkg::dark_grey:   return 31;
                        vic_color_pkg::grey:        return 38;
                        vic_color_pkg::light_green: return 50;
                        vic_color_pkg::light_blue:  return 38;
                        default:                    return 44; // light grey
                endcase
        endfunction

        // reference hue offsets per line type
        function automatic int phase_of(input vic_color_pkg::vic_color_t c, input logic odd);
                case (c)
                        vic_color_pkg::red:         return odd ? 176 : 80;
                        vic_color_pkg::cyan:        return odd ? 48 : 208;
                        vic_color_pkg::purple:      return odd ? 224 : 32;
                        vic_color_pkg::green:       return odd ? 96 : 160;
                        vic_color_pkg::yellow:      return 128;
                        vic_color_pkg::orange:      return odd ? 160 : 96;
                        vic_color_pkg::brown:       return odd ? 144 : 112;
                        vic_color_pkg::pink:        return odd ? 176 : 80;
                        vic_color_pkg::light_green: return odd ? 96 : 160;
                        default:                    return 0; // blues and greys
                endcase
        endfunction

        function automatic int amp_of(input vic_color_pkg::vic_color_t c);
                case (c)
                        vic_color_pkg::purple, vic_color_pkg::green:  return 1;
                        vic_color_pkg::yellow, vic_color_pkg::orange: return 0;
                        vic_color_pkg::black, vic_color_pkg::white, vic_color_pkg::dark_grey,
                        vic_color_pkg::grey, vic_color_pkg::light_grey: return `AMP_NONE;
                        default:                                     return 2;
                endcase
        endfunction

        // truncated 63 * sin from a folded quarter wave
        function automatic int sine_at(input int angle);
                int quadrant;
                int offset;
                int fold;
                int mag;
                quadrant = angle / 64;
                offset   = angle % 64;
                fold     = (quadrant % 2 == 1) ? 64 - offset : offset;
                mag      = int'($floor(63.0 * $sin(half_pi * fold / 64.0) + 1.0e-9));
                return (quadrant >= 2) ? -mag : mag;
        endfunction

        function automatic int chroma_of(input vic_color_pkg::vic_color_t c, input logic odd,
                                         input logic s, input logic b, input logic bu,
                                         input int acc);
                int phase;
                int amp;
                phase = bu ? (odd ? `BURST_PHASE_ODD : `BURST_PHASE_EVEN) : phase_of(c, odd);
                amp   = bu ? int'(`BURST_AMP) : amp_of(c);
                if (s || (b && !bu) || amp == `AMP_NONE) return 0; // muted
                return sine_at((acc + phase) % 256) >>> amp;
        endfunction

        function automatic int composite_of(input vic_color_pkg::vic_color_t c,
                                            input logic odd, input logic s, input logic b,
                                            input logic bu, input int acc);
                int sum;
                sum = luma_of(c, s, b) * 4 + chroma_of(c, odd, s, b, bu, acc);
                if (sum < 0) return 0;
                if (sum > 255) return 255; // top end saturation
                return sum;
        endfunction

        // two stage model pipeline like the encoder
        always @(posedge clk) begin
                if (rst) begin
                        model_acc     <= '0;
                        exp_stage1    <= '0;
                        exp_composite <= '0;
                end else begin
                        exp_stage1     <= `COMPOSITE_W'(composite_of(index, oddline, sync, blank,
                                                                   burst, int'(model_acc)));
                        exp_composite  <= exp_stage1;
                        model_acc      <= model_acc + `PHASE_W'(`SUBCARRIER_STEP);
                end
        end

        check_reset: assert property (@(posedge clk) rst |=> composite == '0)
                else abort_run($sformatf("[FAIL] t=%0t composite after reset: got %0d expected 0",
                                         $time, $sampled(composite)));

        check_composite: assert property (@(posedge clk) disable iff (rst)
                                          composite == exp_composite)
                else abort_run($sformatf("[FAIL] t=%0t composite: got %0d expected %0d", $time,
                                         $sampled(composite), $sampled(exp_composite)));

        initial begin
                #(watchdog_ns);
                abort_run("watchdog expired, the run timed out before all stimulus finished");
        end

        task automatic drive_pixels(input vic_color_pkg::vic_color_t c, input logic odd,
                                    input logic s, input logic b, input logic bu);
                repeat (group_len) begin
                        @(negedge clk);
                        index   = c;
                        oddline = odd;
                        sync    = s;
                        blank   = b;
                        burst   = bu;
                end
        endtask

        task automatic drive_random(input int cycles);
                logic [31:0] r;
                for (int i = 0; i < cycles; i++) begin
                        r = $random(seed);
                        @(negedge clk);
                        index   = vic_color_pkg::vic_color_t'(r[3:0]);
                        oddline = (i / line_len) % 2; // alternate every line
                        sync    = (r[7:4] == 4'd0);   // rare sync pulses
                        blank   = (r[9:8] == 2'd0);
                        burst   = (r[11:10] == 2'd0);
                end
        endtask

        initial begin
                rst            = 1'b1;
                index          = vic_color_pkg::black;
                oddline        = 1'b0;
                sync           = 1'b0;
                blank          = 1'b0;
                burst          = 1'b0;
                repeat (reset_cycles) @(posedge clk);
                @(negedge clk);
                rst = 1'b0;

                for (int odd = 0; odd < 2; odd++) begin
                        foreach (grey_colors[i]) drive_pixels(grey_colors[i], odd, 0, 0, 0);
                end
                for (int odd = 0; odd < 2; odd++) begin
                        foreach (hue_colors[i]) drive_pixels(hue_colors[i], odd, 0, 0, 0);
                end
                for (int odd = 0; odd < 2; odd++) begin
                        drive_pixels(vic_color_pkg::red, odd, 1, 0, 0);    // sync alone
                        drive_pixels(vic_color_pkg::yellow, odd, 0, 1, 0); // blank only
                        drive_pixels(vic_color_pkg::cyan, odd, 0, 1, 1);   // burst window
                        drive_pixels(vic_color_pkg::orange, odd, 1, 1, 1); // sync wins
                        drive_pixels(vic_color_pkg::white, odd, 1, 0, 1);
                end
                drive_random(random_cycles);
                repeat (4) @(negedge clk); // drain the pipeline

                $display("Simulation completed successfully");
                $finish;
        end

endmodule : tb_composite_encoder

/* verilog/composite_encoder.sv */
`timescale 1ns/1ns

`include "composite_defs.svh"

// palette index in, composite sample out, two cycle latency
module composite_encoder (
        input  logic                      clk,
        input  logic                      rst,
        input  vic_color_pkg::vic_color_t index,    // pixel colour
        input  logic                      oddline,  // pal line alternation
        input  logic                      sync,
        input  logic                      blank,
        input  logic                      burst,
        output logic [`COMPOSITE_W-1:0]   composite // to the dac
);

        logic [`LUMA_W-1:0]          luma;   // stage 1 luma
        logic signed [`CHROMA_W-1:0] chroma; // stage 1 chroma

        luma_path i_luma_path (
                .clk   (clk),
                .rst   (rst),
                .index (index),
                .sync  (sync),
                .blank (blank),
                .luma  (luma)
        );

        chroma_path i_chroma_path (
                .clk     (clk),
                .rst     (rst),
                .index   (index),
                .oddline (oddline),
                .sync    (sync),
                .blank   (blank),
                .burst   (burst),
                .chroma  (chroma)
        );

        composite_mixer i_composite_mixer (
                .clk       (clk),
                .rst       (rst),
                .luma      (luma),
                .chroma    (chroma),
                .composite (composite)
        );

endmodule : composite_encoder

/* verilog/composite_mixer.sv */
`timescale 1ns/1ns

`include "composite_defs.svh"

// luma plus chroma into one dac word, one register stage
module composite_mixer (
        input  logic                         clk,
        input  logic                         rst,
        input  logic [`LUMA_W-1:0]           luma,     // unsigned level
        input  logic signed [`CHROMA_W-1:0]  chroma,   // signed subcarrier sample
        output logic [`COMPOSITE_W-1:0]      composite // dac sample
);

        logic [`COMPOSITE_W-1:0]          luma_scaled; // luma x4 spans the dac range
        logic signed [`COMPOSITE_W+1:0]   sum;         // sign plus overflow guard
        logic [`COMPOSITE_W-1:0]          clamped;

        assign luma_scaled = {luma, 2'b00};
        assign sum         = $signed({2'b00, luma_scaled}) + chroma; // chroma sign extends

        // saturate both ends of the dac
        always_comb begin
                if (sum < 0) begin
                        clamped = '0; // below sync tip
                end else if (sum[`COMPOSITE_W+1:`COMPOSITE_W] != 2'b00) begin
                        clamped = '1; // above peak white
                end else begin
                        clamped = sum[`COMPOSITE_W-1:0];
                end
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        composite <= '0;
                end else begin
                        composite <= clamped; // one cycle after the paths
                end
        end

endmodule : composite_mixer

/* verilog/chroma_path.sv */
`timescale 1ns/1ns

`include "composite_defs.svh"

// colour subcarrier modulator with one register stage
module chroma_path (
        input  logic                         clk,
        input  logic                         rst,
        input  vic_color_pkg::vic_color_t    index,   // palette colour of this pixel
        input  logic                         oddline, // selects the alternate phase set
        input  logic                         sync,    // no chroma during sync
        input  logic                         blank,   // no chroma unless burst
        input  logic                         burst,   // colour burst window
        output logic signed [`CHROMA_W-1:0]  chroma   // registered signed sample
);

        // truncated 63 * sin(k * 90deg / 64) for k = 0..63
        localparam logic [5:0] quarter_sine [0:63] = '{
                0,  1,  3,  4,  6,  7,  9,  10,
                12, 13, 15, 16, 18, 19, 21, 22,
                24, 25, 26, 28, 29, 31, 32, 33,
                35, 36, 37, 38, 39, 41, 42, 43,
                44, 45, 46, 47, 48, 49, 50, 51,
                52, 53, 54, 54, 55, 56, 56, 57,
                58, 58, 59, 59, 60, 60, 61, 61,
                61, 62, 62, 62, 62, 62, 62, 62
        };

        logic [`PHASE_W-1:0]          acc;         // free running subcarrier phase
        logic [`PHASE_W-1:0]          table_phase; // palette hue offset
        logic [`PHASE_W-1:0]          eff_phase;   // hue or burst phase
        logic [`PHASE_W-1:0]          phase_sum;   // instantaneous angle
        logic [`AMP_W-1:0]            table_amp;   // palette saturation code
        logic [`AMP_W-1:0]            eff_amp;     // saturation or burst code
        logic [1:0]                   quadrant;    // top two phase bits
        logic [`PHASE_W-3:0]          offset;      // angle inside the quadrant
        logic [`PHASE_W-2:0]          fold_idx;    // mirrored index 0..64
        logic [5:0]                   magnitude;   // |sine| before scaling
        logic signed [`CHROMA_W-1:0]  full_sample; // signed full scale sine
        logic signed [`CHROMA_W-1:0]  chroma_d;
        logic                         mute;        // force zero chroma

        // hue per line type with odd lines mirroring even ones
        always_comb begin
                case (index)
                        vic_color_pkg::red:         table_phase = oddline ? 8'd176 : 8'd80;
                        vic_color_pkg::cyan:        table_phase = oddline ? 8'd48  : 8'd208;
                        vic_color_pkg::purple:      table_phase = oddline ? 8'd224 : 8'd32;
                        vic_color_pkg::green:       table_phase = oddline ? 8'd96  : 8'd160;
                        vic_color_pkg::blue:        table_phase = 8'd0;   // on the axis
                        vic_color_pkg::yellow:      table_phase = 8'd128; // 180 deg both lines
                        vic_color_pkg::orange:      table_phase = oddline ? 8'd160 : 8'd96;
                        vic_color_pkg::brown:       table_phase = oddline ? 8'd144 : 8'd112;
                        vic_color_pkg::pink:        table_phase = oddline ? 8'd176 : 8'd80;
                        vic_color_pkg::light_green: table_phase = oddline ? 8'd96  : 8'd160;
                        vic_color_pkg::light_blue:  table_phase = 8'd0;
                        default:                    table_phase = 8'd0;   // unmodulated greys
                endcase
        end

        // saturation code where bigger is weaker
        always_comb begin
                case (index)
                        vic_color_pkg::red:         table_amp = 3'd2;
                        vic_color_pkg::cyan:        table_amp = 3'd2;
                        vic_color_pkg::purple:      table_amp = 3'd1;
                        vic_color_pkg::green:       table_amp = 3'd1;
                        vic_color_pkg::blue:        table_amp = 3'd2;
                        vic_color_pkg::yellow:      table_amp = 3'd0; // full swing
                        vic_color_pkg::orange:      table_amp = 3'd0; // full swing
                        vic_color_pkg::brown:       table_amp = 3'd2;
                        vic_color_pkg::pink:        table_amp = 3'd2;
                        vic_color_pkg::light_green: table_amp = 3'd2;
                        vic_color_pkg::light_blue:  table_amp = 3'd2;
                        default:                    table_amp = `AMP_W'(`AMP_NONE); // greys
                endcase
        end

        // burst replaces hue and saturation
        assign eff_phase = burst ? (oddline ? `PHASE_W'(`BURST_PHASE_ODD)
                                            : `PHASE_W'(`BURST_PHASE_EVEN))
                                 : table_phase;
        assign eff_amp   = burst ? `BURST_AMP : table_amp;
        assign mute      = sync | (blank & ~burst) | (eff_amp == `AMP_W'(`AMP_NONE));

        assign phase_sum = acc + eff_phase; // wraps mod 256
        assign quadrant  = phase_sum[`PHASE_W-1 -: 2];
        assign offset    = phase_sum[`PHASE_W-3:0];

        // falling quarters read the table backwards
        assign fold_idx  = quadrant[0] ? (7'd64 - {1'b0, offset}) : {1'b0, offset};
        assign magnitude = fold_idx[6] ? 6'd63 : quarter_sine[fold_idx[5:0]]; // 64 is the peak

        // second half of the turn is negative
        assign full_sample = quadrant[1] ? -$signed({2'b00, magnitude})
                                         : $signed({2'b00, magnitude});

        always_comb begin
                if (mute) begin
                        chroma_d = '0;
                end else begin
                        chroma_d = full_sample >>> eff_amp; // floor toward -inf
                end
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        acc    <= '0; // subcarrier restarts at 0 deg
                        chroma <= '0;
                end else begin
                        acc    <= acc + `PHASE_W'(`SUBCARRIER_STEP); // quarter turn per pixel
                        chroma <= chroma_d;
                end
        end

endmodule : chroma_path

/* verilog/luma_path.sv */
`timescale 1ns/1ns

`include "composite_defs.svh"

// palette index to luma level, one register stage
module luma_path (
        input  logic                      clk,
        input  logic                      rst,
        input  vic_color_pkg::vic_color_t index, // palette colour of this pixel
        input  logic                      sync,  // sync tip, highest priority
        input  logic                      blank, // blanking interval
        output logic [`LUMA_W-1:0]        luma   // registered luma code
);

        logic [`LUMA_W-1:0] table_luma; // raw palette brightness
        logic [`LUMA_W-1:0] luma_d;     // after sync/blank override

        // nine brightness steps shared by the sixteen colours
        always_comb begin
                case (index)
                        vic_color_pkg::black:       table_luma = 6'b010011; // step 0
                        vic_color_pkg::white:       table_luma = 6'b111011; // step 8, top
                        vic_color_pkg::red:         table_luma = 6'b011111; // step 2
                        vic_color_pkg::cyan:        table_luma = 6'b101100; // step 6
                        vic_color_pkg::purple:      table_luma = 6'b100010; // step 3
                        vic_color_pkg::green:       table_luma = 6'b100111; // step 5
                        vic_color_pkg::blue:        table_luma = 6'b011100; // step 1
                        vic_color_pkg::yellow:      table_luma = 6'b110010; // step 7
                        vic_color_pkg::orange:      table_luma = 6'b100010; // step 3, as purple
                        vic_color_pkg::brown:       table_luma = 6'b011100; // step 1, as blue
                        vic_color_pkg::pink:        table_luma = 6'b100111; // step 5, as green
                        vic_color_pkg::dark_grey:   table_luma = 6'b011111; // step 2, as red
                        vic_color_pkg::grey:        table_luma = 6'b100110; // step 4
                        vic_color_pkg::light_green: table_luma = 6'b110010; // step 7
                        vic_color_pkg::light_blue:  table_luma = 6'b100110; // step 4
                        vic_color_pkg::light_grey:  table_luma = 6'b101100; // step 6
                        default:                    table_luma = `BLANK_LUMA; // unreachable
                endcase
        end

        // sync beats blank, blank beats the table
        always_comb begin
                if (sync) begin
                        luma_d = `SYNC_LUMA; // drop to sync tip
                end else if (blank) begin
                        luma_d = `BLANK_LUMA; // hold black level
                end else begin
                        luma_d = table_luma; // active picture
                end
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        luma <= '0; // dac sits at zero out of reset
                end else begin
                        luma <= luma_d; // one cycle latency
                end
        end

endmodule : luma_path

/* verilog/vic_color_pkg.sv */
package vic_color_pkg;

        // palette index as the video chip emits it
        typedef enum logic [3:0] {
                black       = 4'd0,
                white       = 4'd1,
                red         = 4'd2,
                cyan        = 4'd3,
                purple      = 4'd4,
                green       = 4'd5,
                blue        = 4'd6,
                yellow      = 4'd7,
                orange      = 4'd8,
                brown       = 4'd9,
                pink        = 4'd10,
                dark_grey   = 4'd11,
                grey        = 4'd12,
                light_green = 4'd13,
                light_blue  = 4'd14,
                light_grey  = 4'd15
        } vic_color_t;

endpackage : vic_color_pkg

/* include/composite_defs.svh */
`ifndef COMPOSITE_DEFS_SVH
`define COMPOSITE_DEFS_SVH

// datapath widths
`define LUMA_W 6
`define PHASE_W 8
`define CHROMA_W 8
`define COMPOSITE_W 8

// amplitude code, 0 is strongest, each step halves
`define AMP_W 3
// code that switches modulation off
`define AMP_NONE 7

// pixel clock is 4x subcarrier, quarter turn per clock
`define SUBCARRIER_STEP 64

// luma override levels
`define SYNC_LUMA 6'b000000
// same code as black in the palette
`define BLANK_LUMA 6'b010011

// colour burst, amplitude code and phase per line type
`define BURST_AMP 3'd2
// 135 deg on even lines
`define BURST_PHASE_EVEN 96
// 225 deg on odd lines
`define BURST_PHASE_ODD 160

`endif
